//--- compile.f
rtl/cpu_pkg.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
verification/cpu_properties.sv
verification/tb_cpu_top.sv

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    localparam word_t RESET_PC = 32'h1c00_0000;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_NOR  = 4'd6;
    localparam alu_op_t ALU_XOR  = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    localparam alu_op_t ALU_LUI  = 4'd11;  // src2 straight through

    // 3R and shift ops match inst[31:15]
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_SLTU    = 17'h00025;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_NOR     = 17'h00028;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [16:0] OPC_SLLI_W  = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W  = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W  = 17'h00091;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;   // inst[31:22]
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;     // inst[31:25]
    localparam logic [9:0]  OPC_LD_W    = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W    = 10'h0a6;
    localparam logic [5:0]  OPC_BEQ     = 6'h16;     // inst[31:26]
    localparam logic [5:0]  OPC_BNE     = 6'h17;
    localparam logic [5:0]  OPC_B       = 6'h14;
    localparam logic [5:0]  OPC_BL      = 6'h15;
    localparam logic [5:0]  OPC_JIRL    = 6'h13;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_t   alu_op;
        word_t     src1;
        word_t     src2;
        word_t     store_data;
        reg_addr_t dest;
        logic      rf_we;
        logic      mem_re;
        logic      mem_we;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;
        reg_addr_t dest;
        logic      rf_we;
        logic      mem_re;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;
        reg_addr_t dest;
        logic      rf_we;
    } mem_wb_t;

    // valid only when a nonzero register will be written
    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        word_t     value;
    } fwd_t;

endpackage

//--- rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk,
    input  logic               reset,
    // instruction sram
    output logic               inst_sram_en,
    output cpu_pkg::word_t     inst_sram_addr,
    input  cpu_pkg::word_t     inst_sram_rdata,
    // data sram
    output logic               data_sram_en,
    output logic               data_sram_we,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    input  cpu_pkg::word_t     data_sram_rdata,
    // writeback trace
    output cpu_pkg::word_t     debug_wb_pc,
    output logic               debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic      stall;
    logic      redirect;
    word_t     redirect_pc;
    word_t     fetch_pc;
    logic      fetch_valid;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      rf_we;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    fwd_t      ex_fwd;
    fwd_t      mem_fwd;
    fwd_t      wb_fwd;

    assign rf_we        = mem_wb.valid && mem_wb.rf_we;
    assign wb_fwd.valid = rf_we && (mem_wb.dest != 5'd0);  // covers the write-then-read cycle
    assign wb_fwd.dest  = mem_wb.dest;
    assign wb_fwd.value = mem_wb.result;

    fetch_stage fetch_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .inst_sram_en   (inst_sram_en),
        .inst_sram_addr (inst_sram_addr),
        .fetch_pc       (fetch_pc),
        .fetch_valid    (fetch_valid)
    );

    decode_stage decode_stage_inst (
        .clk             (clk),
        .reset           (reset),
        .inst_sram_rdata (inst_sram_rdata),
        .fetch_pc        (fetch_pc),
        .fetch_valid     (fetch_valid),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .ex_fwd          (ex_fwd),
        .mem_fwd         (mem_fwd),
        .wb_fwd          (wb_fwd),
        .rf_raddr1       (rf_raddr1),
        .rf_raddr2       (rf_raddr2),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .id_ex           (id_ex)
    );

    register_file register_file_inst (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (mem_wb.dest),
        .wdata  (mem_wb.result)
    );

    execute_stage execute_stage_inst (
        .clk             (clk),
        .reset           (reset),
        .id_ex           (id_ex),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .ex_fwd          (ex_fwd),
        .ex_mem          (ex_mem)
    );

    memory_stage memory_stage_inst (
        .clk               (clk),
        .reset             (reset),
        .ex_mem            (ex_mem),
        .data_sram_rdata   (data_sram_rdata),
        .mem_fwd           (mem_fwd),
        .mem_wb            (mem_wb),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::word_t     inst_sram_rdata,
    input  cpu_pkg::word_t     fetch_pc,
    input  logic               fetch_valid,
    input  cpu_pkg::word_t     rf_rdata1,
    input  cpu_pkg::word_t     rf_rdata2,
    input  cpu_pkg::fwd_t      ex_fwd,
    input  cpu_pkg::fwd_t      mem_fwd,
    input  cpu_pkg::fwd_t      wb_fwd,
    output cpu_pkg::reg_addr_t rf_raddr1,
    output cpu_pkg::reg_addr_t rf_raddr2,
    output logic               stall,
    output logic               redirect,
    output cpu_pkg::word_t     redirect_pc,
    output cpu_pkg::id_ex_t    id_ex
);
    import cpu_pkg::*;

    word_t     inst;
    word_t     held_inst;
    logic      use_held;
    logic      is_add, is_sub, is_slt, is_sltu, is_and, is_or, is_nor, is_xor;
    logic      is_slli, is_srli, is_srai, is_addi, is_lu12i, is_ld, is_st;
    logic      is_beq, is_bne, is_b, is_bl, is_jirl;
    logic      is_3r;
    logic      src2_is_imm;
    logic      use_rj;
    logic      use_rkd;
    logic      load_in_ex;
    word_t     imm;
    word_t     offs16;
    word_t     offs26;
    word_t     rj_value;
    word_t     rkd_value;
    alu_op_t   alu_op;
    id_ex_t    id_ex_next;

    // execute first, then memory, then writeback
    function automatic word_t forward(
        input reg_addr_t addr,
        input word_t     rf_value,
        input fwd_t      ex_f,
        input fwd_t      mem_f,
        input fwd_t      wb_f
    );
        if (ex_f.valid && ex_f.dest == addr) begin
            return ex_f.value;
        end else if (mem_f.valid && mem_f.dest == addr) begin
            return mem_f.value;
        end else if (wb_f.valid && wb_f.dest == addr) begin
            return wb_f.value;
        end
        return rf_value;
    endfunction

    // the SRAM word is gone after a stall cycle
    assign inst = use_held ? held_inst : inst_sram_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            use_held <= 1'b0;
        end else begin
            use_held <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            held_inst <= inst;
        end
    end

    assign is_add   = inst[31:15] == OPC_ADD_W;
    assign is_sub   = inst[31:15] == OPC_SUB_W;
    assign is_slt   = inst[31:15] == OPC_SLT;
    assign is_sltu  = inst[31:15] == OPC_SLTU;
    assign is_and   = inst[31:15] == OPC_AND;
    assign is_or    = inst[31:15] == OPC_OR;
    assign is_nor   = inst[31:15] == OPC_NOR;
    assign is_xor   = inst[31:15] == OPC_XOR;
    assign is_slli  = inst[31:15] == OPC_SLLI_W;
    assign is_srli  = inst[31:15] == OPC_SRLI_W;
    assign is_srai  = inst[31:15] == OPC_SRAI_W;
    assign is_addi  = inst[31:22] == OPC_ADDI_W;
    assign is_lu12i = inst[31:25] == OPC_LU12I_W;
    assign is_ld    = inst[31:22] == OPC_LD_W;
    assign is_st    = inst[31:22] == OPC_ST_W;
    assign is_beq   = inst[31:26] == OPC_BEQ;
    assign is_bne   = inst[31:26] == OPC_BNE;
    assign is_b     = inst[31:26] == OPC_B;
    assign is_bl    = inst[31:26] == OPC_BL;
    assign is_jirl  = inst[31:26] == OPC_JIRL;

    assign is_3r       = is_add | is_sub | is_slt | is_sltu | is_and | is_or | is_nor | is_xor;
    assign src2_is_imm = is_slli | is_srli | is_srai | is_addi | is_lu12i | is_ld | is_st
                       | is_bl | is_jirl;
    assign use_rj      = !(is_b || is_bl || is_lu12i);
    assign use_rkd     = is_3r | is_beq | is_bne | is_st;

    assign rf_raddr1 = inst[9:5];
    assign rf_raddr2 = (is_beq || is_bne || is_st) ? inst[4:0] : inst[14:10];

    assign rj_value  = forward(rf_raddr1, rf_rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign rkd_value = forward(rf_raddr2, rf_rdata2, ex_fwd, mem_fwd, wb_fwd);

    assign imm    = (is_bl || is_jirl) ? 32'd4                     // link value pc + 4
                  : is_lu12i           ? {inst[24:5], 12'b0}
                  :                      {{20{inst[21]}}, inst[21:10]};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign alu_op = is_sub              ? ALU_SUB
                  : is_slt              ? ALU_SLT
                  : is_sltu             ? ALU_SLTU
                  : is_and              ? ALU_AND
                  : is_or               ? ALU_OR
                  : is_nor              ? ALU_NOR
                  : is_xor              ? ALU_XOR
                  : is_slli             ? ALU_SLL
                  : is_srli             ? ALU_SRL
                  : is_srai             ? ALU_SRA
                  : is_lu12i            ? ALU_LUI
                  :                       ALU_ADD;

    // load result not ready before memory
    assign load_in_ex = id_ex.valid && id_ex.mem_re && (id_ex.dest != 5'd0);
    assign stall = fetch_valid && load_in_ex
                && ((use_rj && rf_raddr1 == id_ex.dest) || (use_rkd && rf_raddr2 == id_ex.dest));

    assign redirect = fetch_valid && !stall
                   && ((is_beq && rj_value == rkd_value) || (is_bne && rj_value != rkd_value)
                       || is_b || is_bl || is_jirl);
    assign redirect_pc = is_jirl ? rj_value + offs16
                       : fetch_pc + ((is_b || is_bl) ? offs26 : offs16);

    always_comb begin
        id_ex_next.valid      = fetch_valid && !stall;  // bubble on stall
        id_ex_next.pc         = fetch_pc;
        id_ex_next.alu_op     = alu_op;
        id_ex_next.src1       = (is_bl || is_jirl) ? fetch_pc : rj_value;
        id_ex_next.src2       = src2_is_imm ? imm : rkd_value;
        id_ex_next.store_data = rkd_value;
        id_ex_next.dest       = is_bl ? 5'd1 : inst[4:0];
        id_ex_next.rf_we      = is_3r | is_slli | is_srli | is_srai | is_addi | is_lu12i
                              | is_ld | is_bl | is_jirl;
        id_ex_next.mem_re     = is_ld;
        id_ex_next.mem_we     = is_st;
    end

    always_ff @(posedge clk) begin
        id_ex <= id_ex_next;
        if (reset) begin
            id_ex.valid  <= 1'b0;
            id_ex.rf_we  <= 1'b0;
            id_ex.mem_re <= 1'b0;
            id_ex.mem_we <= 1'b0;
        end
    end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::id_ex_t  id_ex,
    output logic             data_sram_en,
    output logic             data_sram_we,
    output cpu_pkg::word_t   data_sram_addr,
    output cpu_pkg::word_t   data_sram_wdata,
    output cpu_pkg::fwd_t    ex_fwd,
    output cpu_pkg::ex_mem_t ex_mem
);
    import cpu_pkg::*;

    word_t        result;
    logic [4:0]   shamt;
    ex_mem_t      ex_mem_next;

    assign shamt = id_ex.src2[4:0];

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  result = id_ex.src1 + id_ex.src2;
            ALU_SUB:  result = id_ex.src1 - id_ex.src2;
            ALU_SLT:  result = {31'd0, $signed(id_ex.src1) < $signed(id_ex.src2)};
            ALU_SLTU: result = {31'd0, id_ex.src1 < id_ex.src2};
            ALU_AND:  result = id_ex.src1 & id_ex.src2;
            ALU_OR:   result = id_ex.src1 | id_ex.src2;
            ALU_NOR:  result = ~(id_ex.src1 | id_ex.src2);
            ALU_XOR:  result = id_ex.src1 ^ id_ex.src2;
            ALU_SLL:  result = id_ex.src1 << shamt;
            ALU_SRL:  result = id_ex.src1 >> shamt;
            ALU_SRA:  result = $signed(id_ex.src1) >>> shamt;
            ALU_LUI:  result = id_ex.src2;
            default:  result = 32'd0;
        endcase
    end

    // word accesses only, low address bits dropped
    assign data_sram_en    = id_ex.valid && (id_ex.mem_re || id_ex.mem_we);
    assign data_sram_we    = id_ex.valid && id_ex.mem_we;
    assign data_sram_addr  = {result[31:2], 2'b00};
    assign data_sram_wdata = id_ex.store_data;

    assign ex_fwd.valid = id_ex.valid && id_ex.rf_we && !id_ex.mem_re && (id_ex.dest != 5'd0);
    assign ex_fwd.dest  = id_ex.dest;
    assign ex_fwd.value = result;

    assign ex_mem_next = '{valid:  id_ex.valid,
                           pc:     id_ex.pc,
                           result: result,
                           dest:   id_ex.dest,
                           rf_we:  id_ex.rf_we,
                           mem_re: id_ex.mem_re};

    always_ff @(posedge clk) begin
        ex_mem <= ex_mem_next;
        if (reset) begin
            ex_mem.valid  <= 1'b0;
            ex_mem.rf_we  <= 1'b0;
            ex_mem.mem_re <= 1'b0;
        end
    end

endmodule

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    output logic           inst_sram_en,
    output cpu_pkg::word_t inst_sram_addr,
    output cpu_pkg::word_t fetch_pc,
    output logic           fetch_valid
);
    import cpu_pkg::*;

    word_t pc;
    word_t next_pc;

    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (stall || !inst_sram_en) begin
            next_pc = pc;  // hold, also for the idle cycle after reset
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= RESET_PC;
            inst_sram_en <= 1'b0;
            fetch_valid  <= 1'b0;
        end else begin
            pc           <= next_pc;
            inst_sram_en <= 1'b1;
            if (!stall) begin
                fetch_valid <= inst_sram_en && !redirect;  // kill wrong-path word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fetch_pc <= pc;
        end
    end

    assign inst_sram_addr = pc;

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::fwd_t      mem_fwd,
    output cpu_pkg::mem_wb_t   mem_wb,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic               debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);
    import cpu_pkg::*;

    word_t final_result;

    assign final_result = ex_mem.mem_re ? data_sram_rdata : ex_mem.result;  // load data lands here

    assign mem_fwd.valid = ex_mem.valid && ex_mem.rf_we && (ex_mem.dest != 5'd0);
    assign mem_fwd.dest  = ex_mem.dest;
    assign mem_fwd.value = final_result;

    always_ff @(posedge clk) begin
        mem_wb.pc     <= ex_mem.pc;
        mem_wb.result <= final_result;
        mem_wb.dest   <= ex_mem.dest;
        if (reset) begin
            mem_wb.valid <= 1'b0;
            mem_wb.rf_we <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.valid;
            mem_wb.rf_we <= ex_mem.rf_we;
        end
    end

    // trace
    assign debug_wb_pc       = mem_wb.pc;
    assign debug_wb_rf_we    = mem_wb.valid && mem_wb.rf_we;
    assign debug_wb_rf_wnum  = mem_wb.dest;
    assign debug_wb_rf_wdata = mem_wb.result;

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_cpu_top -o tb_cpu_top

# the result depends on the pass line in the simulation output
./obj_dir/tb_cpu_top | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null
echo "simulation passed"

//--- verification/cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties (
    input logic           clk,
    input logic           reset,
    input logic           data_sram_en,
    input logic           data_sram_we,
    input cpu_pkg::word_t data_sram_addr
);

    // word accesses only
    assert property (@(posedge clk) disable iff (reset)
        data_sram_en |-> data_sram_addr[1:0] == 2'b00)
        else $error("data_sram_en with unaligned address %h", data_sram_addr);

    assert property (@(posedge clk) disable iff (reset)
        $rose(data_sram_we) |-> data_sram_en)
        else $error("data_sram_we rose without data_sram_en");

endmodule

bind execute_stage cpu_properties cpu_properties_inst (
    .clk            (clk),
    .reset          (reset),
    .data_sram_en   (data_sram_en),
    .data_sram_we   (data_sram_we),
    .data_sram_addr (data_sram_addr)
);

//--- verification/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;
    import cpu_pkg::*;

    logic      clk;
    logic      reset;
    logic      inst_sram_en;
    word_t     inst_sram_addr;
    word_t     inst_sram_rdata;
    logic      data_sram_en;
    logic      data_sram_we;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    word_t     data_sram_rdata;
    word_t     debug_wb_pc;
    logic      debug_wb_rf_we;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    word_t     imem [256];
    word_t     dmem [256];
    int        prog_len;
    int        errors;
    int        checks;
    logic      i_en;
    word_t     i_addr;
    logic      d_en;
    logic      d_we;
    word_t     d_addr;
    word_t     d_wdata;
    word_t     trace_pc [$];
    reg_addr_t trace_num [$];
    word_t     trace_val [$];
    word_t     exp_pc [$];
    reg_addr_t exp_num [$];
    word_t     exp_val [$];

    cpu_top cpu_top_inst (.*);

    always #4 clk = ~clk;

    // synchronous SRAMs with data 1 ns after the edge
    always @(posedge clk) begin
        i_en    = inst_sram_en;
        i_addr  = inst_sram_addr;
        d_en    = data_sram_en;
        d_we    = data_sram_we;
        d_addr  = data_sram_addr;
        d_wdata = data_sram_wdata;
        #1;
        if (i_en === 1'b1) begin
            inst_sram_rdata = imem[i_addr[9:2]];
        end
        if (d_en === 1'b1) begin
            data_sram_rdata = dmem[d_addr[9:2]];
            if (d_we === 1'b1) begin
                dmem[d_addr[9:2]] = d_wdata;
            end
        end
    end

    // records each trace write
    always @(posedge clk) begin
        if (debug_wb_rf_we === 1'b1) begin
            trace_pc.push_back(debug_wb_pc);
            trace_num.push_back(debug_wb_rf_wnum);
            trace_val.push_back(debug_wb_rf_wdata);
        end
    end

    function automatic word_t enc_3r(logic [16:0] opc, int rd, int rj, int rk);
        return {opc, rk[4:0], rj[4:0], rd[4:0]};  // also ui5 shifts
    endfunction

    function automatic word_t enc_i12(logic [9:0] opc, int rd, int rj, int imm);
        return {opc, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_lu12i(int rd, int si20);
        return {OPC_LU12I_W, si20[19:0], rd[4:0]};
    endfunction

    function automatic word_t enc_br16(logic [5:0] opc, int rj, int rd, int offs);
        return {opc, offs[17:2], rj[4:0], rd[4:0]};
    endfunction

    function automatic word_t enc_b26(logic [5:0] opc, int offs);
        return {opc, offs[17:2], offs[27:18]};
    endfunction

    function automatic word_t pc_at(int idx);
        return RESET_PC + word_t'(4 * idx);
    endfunction

    task automatic check_value(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic emit(word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic expect_wb(int idx, int rd, word_t value);
        exp_pc.push_back(pc_at(idx));
        exp_num.push_back(rd[4:0]);
        exp_val.push_back(value);
    endtask

    task automatic begin_test();
        @(posedge clk);
        #1;
        reset = 1'b1;
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;
            dmem[i] = 32'h5a5a_0000 ^ {22'd0, i[7:0], 2'b00};
        end
        exp_pc.delete();
        exp_num.delete();
        exp_val.delete();
    endtask

    task automatic apply_reset();
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            check_value("inst_sram_en", 32'(inst_sram_en), 32'd0);
            check_value("data_sram_en", 32'(data_sram_en), 32'd0);
            check_value("data_sram_we", 32'(data_sram_we), 32'd0);
            check_value("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'd0);
        end
        // drops what retired before reset took hold
        trace_pc.delete();
        trace_num.delete();
        trace_val.delete();
        reset = 1'b0;
    endtask

    task automatic run_program();
        int cycles;
        int n;
        emit(enc_b26(OPC_B, 0));  // park on a self loop
        apply_reset();
        cycles = 0;
        while (inst_sram_en !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (inst_sram_en !== 1'b1) begin
            errors++;
            $display("timeout at %0t: no instruction fetch after reset", $time);
        end
        check_value("inst_sram_addr", inst_sram_addr, RESET_PC);
        cycles = 0;
        while (trace_pc.size() < exp_pc.size() && cycles < 300) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (trace_pc.size() < exp_pc.size()) begin
            errors++;
            $display("timeout at %0t: only %0d of %0d register writes seen",
                     $time, trace_pc.size(), exp_pc.size());
        end
        // extra writes would show up here
        for (cycles = 0; cycles < 12; cycles++) begin
            @(posedge clk);
        end
        check_value("trace count", 32'(trace_pc.size()), 32'(exp_pc.size()));
        n = (trace_pc.size() < exp_pc.size()) ? trace_pc.size() : exp_pc.size();
        for (int i = 0; i < n; i++) begin
            check_value("debug_wb_pc", trace_pc[i], exp_pc[i]);
            check_value("debug_wb_rf_wnum", 32'(trace_num[i]), 32'(exp_num[i]));
            check_value("debug_wb_rf_wdata", trace_val[i], exp_val[i]);
        end
    endtask

    task automatic test_reset();
        int cycles;
        begin_test();
        emit(enc_i12(OPC_ADDI_W, 1, 1, 1));
        emit(enc_i12(OPC_LD_W, 2, 0, 'h40));
        emit(enc_b26(OPC_B, -8));
        apply_reset();
        cycles = 0;
        while (trace_pc.size() < 4 && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (trace_pc.size() < 4) begin
            errors++;
            $display("timeout at %0t: busy loop wrote only %0d registers before reset",
                     $time, trace_pc.size());
        end
        // reset again with loads and writes in flight
        begin_test();
        emit(enc_i12(OPC_ADDI_W, 1, 0, 1));
        expect_wb(0, 1, 32'd1);
        run_program();
    endtask

    task automatic test_alu_chain();
        begin_test();
        emit(enc_i12(OPC_ADDI_W, 1, 0, 5));
        emit(enc_i12(OPC_ADDI_W, 2, 0, -3));
        emit(enc_3r(OPC_ADD_W, 3, 1, 2));
        emit(enc_3r(OPC_SUB_W, 4, 3, 1));
        emit(enc_3r(OPC_SLT, 5, 4, 1));
        emit(enc_3r(OPC_SLTU, 6, 4, 1));
        emit(enc_3r(OPC_AND, 7, 4, 1));
        emit(enc_3r(OPC_OR, 8, 7, 2));
        emit(enc_3r(OPC_NOR, 9, 8, 5));
        emit(enc_3r(OPC_XOR, 10, 9, 3));
        emit(enc_3r(OPC_ADD_W, 11, 10, 1));
        expect_wb(0, 1, 32'd5);
        expect_wb(1, 2, 32'hffff_fffd);
        expect_wb(2, 3, 32'd2);
        expect_wb(3, 4, 32'hffff_fffd);
        expect_wb(4, 5, 32'd1);      // -3 < 5 signed
        expect_wb(5, 6, 32'd0);      // but not unsigned
        expect_wb(6, 7, 32'd5);
        expect_wb(7, 8, 32'hffff_fffd);
        expect_wb(8, 9, 32'd2);
        expect_wb(9, 10, 32'd0);
        expect_wb(10, 11, 32'd5);
        run_program();
    endtask

    task automatic test_shifts();
        begin_test();
        emit(enc_lu12i(1, 'h80001));
        emit(enc_3r(OPC_SRAI_W, 2, 1, 4));
        emit(enc_3r(OPC_SRLI_W, 3, 1, 4));
        emit(enc_3r(OPC_SLLI_W, 4, 1, 3));
        emit(enc_i12(OPC_ADDI_W, 5, 0, 'h25));
        emit(enc_3r(OPC_SLLI_W, 6, 5, 31));
        emit(enc_3r(OPC_SRAI_W, 7, 6, 31));
        emit(enc_3r(OPC_SRLI_W, 8, 6, 31));
        emit(enc_lu12i(9, 'h12345));
        emit(enc_i12(OPC_ADDI_W, 10, 9, 'h678));
        emit(enc_3r(OPC_SRAI_W, 11, 10, 0));
        expect_wb(0, 1, 32'h8000_1000);
        expect_wb(1, 2, 32'hf800_0100);
        expect_wb(2, 3, 32'h0800_0100);
        expect_wb(3, 4, 32'h0000_8000);
        expect_wb(4, 5, 32'h0000_0025);
        expect_wb(5, 6, 32'h8000_0000);
        expect_wb(6, 7, 32'hffff_ffff);
        expect_wb(7, 8, 32'h0000_0001);
        expect_wb(8, 9, 32'h1234_5000);
        expect_wb(9, 10, 32'h1234_5678);
        expect_wb(10, 11, 32'h1234_5678);
        run_program();
    endtask

    task automatic test_load_store();
        begin_test();
        emit(enc_i12(OPC_ADDI_W, 1, 0, 'h100));
        emit(enc_lu12i(2, 'habcde));
        emit(enc_i12(OPC_ADDI_W, 2, 2, 'h123));
        emit(enc_i12(OPC_ST_W, 2, 1, 0));
        emit(enc_i12(OPC_ST_W, 1, 1, 8));
        emit(enc_i12(OPC_LD_W, 3, 1, 0));
        emit(enc_3r(OPC_ADD_W, 4, 3, 1));   // load-use
        emit(enc_i12(OPC_LD_W, 5, 1, 8));
        emit(enc_i12(OPC_LD_W, 6, 1, 4));
        emit(enc_3r(OPC_SUB_W, 7, 6, 5));
        emit(enc_i12(OPC_ST_W, 7, 1, 12));
        expect_wb(0, 1, 32'h0000_0100);
        expect_wb(1, 2, 32'habcd_e000);
        expect_wb(2, 2, 32'habcd_e123);
        expect_wb(5, 3, 32'habcd_e123);
        expect_wb(6, 4, 32'habcd_e223);
        expect_wb(7, 5, 32'h0000_0100);
        expect_wb(8, 6, 32'h5a5a_0104);   // never written so still the fill
        expect_wb(9, 7, 32'h5a5a_0004);
        run_program();
        check_value("dmem[0x100]", dmem[64], 32'habcd_e123);
        check_value("dmem[0x104]", dmem[65], 32'h5a5a_0104);
        check_value("dmem[0x108]", dmem[66], 32'h0000_0100);
        check_value("dmem[0x10c]", dmem[67], 32'h5a5a_0004);
    endtask

    task automatic test_control_flow();
        begin_test();
        emit(enc_i12(OPC_ADDI_W, 1, 0, 7));
        emit(enc_i12(OPC_ADDI_W, 2, 0, 7));
        emit(enc_br16(OPC_BEQ, 1, 2, 12));   // taken to 5
        emit(enc_i12(OPC_ADDI_W, 3, 0, 1));
        emit(enc_i12(OPC_ADDI_W, 3, 0, 2));
        emit(enc_br16(OPC_BNE, 1, 2, 8));    // falls through
        emit(enc_i12(OPC_ADDI_W, 4, 0, 3));
        emit(enc_br16(OPC_BNE, 1, 4, 8));    // taken to 9
        emit(enc_i12(OPC_ADDI_W, 5, 0, 9));
        emit(enc_br16(OPC_BEQ, 1, 4, 8));    // falls through
        emit(enc_b26(OPC_BL, 12));           // to 13 with r1 = pc of 11
        emit(enc_i12(OPC_ADDI_W, 6, 0, 1));
        emit(enc_b26(OPC_B, 12));            // to 15
        emit(enc_br16(OPC_JIRL, 1, 7, 4));   // back to 12
        emit(enc_i12(OPC_ADDI_W, 8, 0, 1));
        emit(enc_i12(OPC_ADDI_W, 9, 0, 'h55));
        expect_wb(0, 1, 32'd7);
        expect_wb(1, 2, 32'd7);
        expect_wb(6, 4, 32'd3);
        expect_wb(10, 1, pc_at(11));
        expect_wb(13, 7, pc_at(14));
        expect_wb(15, 9, 32'h55);
        run_program();
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        errors          = 0;
        checks          = 0;
        prog_len        = 0;
        test_reset();
        test_alu_chain();
        test_shifts();
        test_load_store();
        test_control_flow();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
